//--- croc_lite.f
+incdir+design
design/croc_lite_pkg.sv
design/bus_decoder.sv
design/sram_bank.sv
design/soc_ctrl_regs.sv
design/gpio_regs.sv
design/timer_unit.sv
design/croc_lite_domain.sv
tests/croc_lite_asserts.sv
tests/croc_lite_tb.sv

//--- design/bus_decoder.sv
`include "croc_lite_macros.svh"

module bus_decoder (
  input  logic                    clk_i,
  input  logic                    rst_i,
  input  croc_lite_pkg::bus_req_t mgr_req_i,
  output croc_lite_pkg::bus_rsp_t mgr_rsp_o,
  output croc_lite_pkg::bus_req_t sram_req_o,
  output croc_lite_pkg::bus_req_t ctrl_req_o,
  output croc_lite_pkg::bus_req_t gpio_req_o,
  output croc_lite_pkg::bus_req_t timer_req_o,
  input  croc_lite_pkg::bus_rsp_t sram_rsp_i,
  input  croc_lite_pkg::bus_rsp_t ctrl_rsp_i,
  input  croc_lite_pkg::bus_rsp_t gpio_rsp_i,
  input  croc_lite_pkg::bus_rsp_t timer_rsp_i
);
  import croc_lite_pkg::*;

  localparam addr_t PeriphMask = ~addr_t'(`CROC_PERIPH_SIZE - 1);
  localparam addr_t SramLast   = addr_t'(`CROC_SRAM_BASE + `CROC_SRAM_WORDS * 4 - 1);

  target_e tgt_sel;
  target_e tgt_q;
  addr_t   page;
  logic    gnt_sel;
  logic    accept;
  logic    rsp_pend_q;

  // ----------------------------------------
  // Address decode
  // ----------------------------------------
  assign page = mgr_req_i.addr & PeriphMask;

  always_comb begin
    if (mgr_req_i.addr >= `CROC_SRAM_BASE && mgr_req_i.addr <= SramLast) begin
      tgt_sel = TGT_SRAM;
    end else if (page == `CROC_SOC_CTRL_BASE) begin
      tgt_sel = TGT_SOC_CTRL;
    end else if (page == `CROC_GPIO_BASE) begin
      tgt_sel = TGT_GPIO;
    end else if (page == `CROC_TIMER_BASE) begin
      tgt_sel = TGT_TIMER;
    end else begin
      tgt_sel = TGT_ERR;
    end
  end

  // Fan out, req only towards the selected target
  always_comb begin
    sram_req_o      = mgr_req_i;
    sram_req_o.req  = mgr_req_i.req && (tgt_sel == TGT_SRAM);
    ctrl_req_o      = mgr_req_i;
    ctrl_req_o.req  = mgr_req_i.req && (tgt_sel == TGT_SOC_CTRL);
    gpio_req_o      = mgr_req_i;
    gpio_req_o.req  = mgr_req_i.req && (tgt_sel == TGT_GPIO);
    timer_req_o     = mgr_req_i;
    timer_req_o.req = mgr_req_i.req && (tgt_sel == TGT_TIMER);
  end

  // Error subordinate grants whatever lands on it
  always_comb begin
    case (tgt_sel)
      TGT_SRAM:     gnt_sel = sram_rsp_i.gnt;
      TGT_SOC_CTRL: gnt_sel = ctrl_rsp_i.gnt;
      TGT_GPIO:     gnt_sel = gpio_rsp_i.gnt;
      TGT_TIMER:    gnt_sel = timer_rsp_i.gnt;
      default:      gnt_sel = mgr_req_i.req;
    endcase
  end

  assign accept = mgr_req_i.req && gnt_sel;

  // ----------------------------------------
  // Response tracking
  // ----------------------------------------
  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      tgt_q      <= TGT_ERR;
      rsp_pend_q <= 1'b0;
    end else begin
      rsp_pend_q <= accept;
      if (accept) begin
        tgt_q <= tgt_sel;
      end
    end
  end

  always_comb begin
    mgr_rsp_o.gnt = gnt_sel;
    case (tgt_q)
      TGT_SRAM: begin
        mgr_rsp_o.rvalid = sram_rsp_i.rvalid;
        mgr_rsp_o.rdata  = sram_rsp_i.rdata;
        mgr_rsp_o.err    = sram_rsp_i.err;
      end
      TGT_SOC_CTRL: begin
        mgr_rsp_o.rvalid = ctrl_rsp_i.rvalid;
        mgr_rsp_o.rdata  = ctrl_rsp_i.rdata;
        mgr_rsp_o.err    = ctrl_rsp_i.err;
      end
      TGT_GPIO: begin
        mgr_rsp_o.rvalid = gpio_rsp_i.rvalid;
        mgr_rsp_o.rdata  = gpio_rsp_i.rdata;
        mgr_rsp_o.err    = gpio_rsp_i.err;
      end
      TGT_TIMER: begin
        mgr_rsp_o.rvalid = timer_rsp_i.rvalid;
        mgr_rsp_o.rdata  = timer_rsp_i.rdata;
        mgr_rsp_o.err    = timer_rsp_i.err;
      end
      default: begin
        // Built-in error responder
        mgr_rsp_o.rvalid = rsp_pend_q;
        mgr_rsp_o.rdata  = `CROC_ERR_RDATA;
        mgr_rsp_o.err    = 1'b1;
      end
    endcase
  end

endmodule

//--- design/croc_lite_domain.sv
`include "croc_lite_macros.svh"

module croc_lite_domain (
  input  logic                           clk_i,
  input  logic                           rst_i,
  input  logic                           fetch_en_i,
  input  croc_lite_pkg::bus_req_t        bus_req_i,
  output croc_lite_pkg::bus_rsp_t        bus_rsp_o,
  input  croc_lite_pkg::gpio_t           gpio_i,
  output croc_lite_pkg::gpio_t           gpio_o,
  output croc_lite_pkg::gpio_t           gpio_out_en_o,
  output croc_lite_pkg::gpio_t           gpio_in_sync_o,
  input  logic [`CROC_NUM_EXT_IRQS-1:0]  irqs_i,
  output croc_lite_pkg::irq_vec_t        irqs_o,
  output croc_lite_pkg::addr_t           boot_addr_o,
  output logic                           fetch_enable_o
);

  // Subordinate buses
  croc_lite_pkg::bus_req_t sram_req, ctrl_req, gpio_req, timer_req;
  croc_lite_pkg::bus_rsp_t sram_rsp, ctrl_rsp, gpio_rsp, timer_rsp;

  logic timer_irq;
  logic gpio_irq;

  // Timer at bit 0, GPIO at bit 1, external lines above
  assign irqs_o = {irqs_i, gpio_irq, timer_irq};

  // ----------------------------------------
  // Interconnect
  // ----------------------------------------
  bus_decoder i_bus_decoder (
    .clk_i,
    .rst_i,
    .mgr_req_i   ( bus_req_i ),
    .mgr_rsp_o   ( bus_rsp_o ),
    .sram_req_o  ( sram_req  ),
    .ctrl_req_o  ( ctrl_req  ),
    .gpio_req_o  ( gpio_req  ),
    .timer_req_o ( timer_req ),
    .sram_rsp_i  ( sram_rsp  ),
    .ctrl_rsp_i  ( ctrl_rsp  ),
    .gpio_rsp_i  ( gpio_rsp  ),
    .timer_rsp_i ( timer_rsp )
  );

  // ----------------------------------------
  // Memory and peripherals
  // ----------------------------------------
  sram_bank i_sram (
    .clk_i,
    .rst_i,
    .req_i ( sram_req ),
    .rsp_o ( sram_rsp )
  );

  soc_ctrl_regs i_soc_ctrl (
    .clk_i,
    .rst_i,
    .req_i          ( ctrl_req       ),
    .rsp_o          ( ctrl_rsp       ),
    .fetch_en_i,
    .boot_addr_o,
    .fetch_enable_o
  );

  gpio_regs i_gpio (
    .clk_i,
    .rst_i,
    .req_i          ( gpio_req ),
    .rsp_o          ( gpio_rsp ),
    .gpio_i,
    .gpio_o,
    .gpio_out_en_o,
    .gpio_in_sync_o,
    .irq_o          ( gpio_irq )
  );

  timer_unit i_timer (
    .clk_i,
    .rst_i,
    .req_i ( timer_req ),
    .rsp_o ( timer_rsp ),
    .irq_o ( timer_irq )
  );

endmodule

//--- design/croc_lite_macros.svh
`ifndef CROC_LITE_MACROS_SVH
`define CROC_LITE_MACROS_SVH

// Bus widths
`define CROC_ADDR_W 32
`define CROC_DATA_W 32

// Pin and interrupt counts
`define CROC_GPIO_COUNT 16
`define CROC_NUM_EXT_IRQS 4

// ----------------------------------------
// Address map
// ----------------------------------------
`define CROC_SRAM_BASE 32'h1000_0000
`define CROC_SRAM_WORDS 1024
`define CROC_SOC_CTRL_BASE 32'h0300_0000
`define CROC_GPIO_BASE 32'h0300_1000
`define CROC_TIMER_BASE 32'h0300_2000
`define CROC_PERIPH_SIZE 32'h0000_1000

// Read data returned for unmapped addresses
`define CROC_ERR_RDATA 32'hBADCAB1E

`endif

//--- design/croc_lite_pkg.sv
`include "croc_lite_macros.svh"

package croc_lite_pkg;

  typedef logic [`CROC_ADDR_W-1:0]       addr_t;
  typedef logic [`CROC_DATA_W-1:0]       data_t;
  typedef logic [`CROC_DATA_W/8-1:0]     strb_t;
  typedef logic [`CROC_GPIO_COUNT-1:0]   gpio_t;

  // Timer and GPIO lines sit below the external ones
  typedef logic [`CROC_NUM_EXT_IRQS+1:0] irq_vec_t;

  // ----------------------------------------
  // Bus channels
  // ----------------------------------------
  typedef struct packed {
    logic  req;
    logic  we;
    strb_t be;
    addr_t addr;
    data_t wdata;
  } bus_req_t;

  typedef struct packed {
    logic  gnt;
    logic  rvalid;
    data_t rdata;
    logic  err;
  } bus_rsp_t;

  // Decoder routing targets
  typedef enum logic [2:0] {
    TGT_SRAM,
    TGT_SOC_CTRL,
    TGT_GPIO,
    TGT_TIMER,
    TGT_ERR
  } target_e;

endpackage

//--- design/gpio_regs.sv
`include "croc_lite_macros.svh"

module gpio_regs (
  input  logic                    clk_i,
  input  logic                    rst_i,
  input  croc_lite_pkg::bus_req_t req_i,
  output croc_lite_pkg::bus_rsp_t rsp_o,
  input  croc_lite_pkg::gpio_t    gpio_i,
  output croc_lite_pkg::gpio_t    gpio_o,
  output croc_lite_pkg::gpio_t    gpio_out_en_o,
  output croc_lite_pkg::gpio_t    gpio_in_sync_o,
  output logic                    irq_o
);
  import croc_lite_pkg::*;

  localparam int unsigned OffW = $clog2(`CROC_PERIPH_SIZE);

  logic [OffW-3:0] word_off;
  logic            accept;
  logic            wr;
  gpio_t           out_en_q, out_q, mask_q, pend_q;
  gpio_t           in_meta_q, in_sync_q, in_prev_q;
  gpio_t           rise;
  gpio_t           clear;
  logic            rvalid_q;
  data_t           rdata_q;
  data_t           read_data;

  assign accept   = req_i.req;
  assign wr       = accept && req_i.we;
  assign word_off = req_i.addr[OffW-1:2];

  // ----------------------------------------
  // Input synchronizer and edge detect
  // ----------------------------------------
  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      in_meta_q <= '0;
      in_sync_q <= '0;
      in_prev_q <= '0;
    end else begin
      in_meta_q <= gpio_i;
      in_sync_q <= in_meta_q;
      in_prev_q <= in_sync_q;
    end
  end

  assign rise  = in_sync_q & ~in_prev_q;
  assign clear = (wr && word_off == 'd4) ? req_i.wdata[`CROC_GPIO_COUNT-1:0] : '0;

  // ----------------------------------------
  // Registers
  // ----------------------------------------
  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      out_en_q <= '0;
      out_q    <= '0;
      mask_q   <= '0;
      pend_q   <= '0;
    end else begin
      if (wr && word_off == 'd0) out_en_q <= req_i.wdata[`CROC_GPIO_COUNT-1:0];
      if (wr && word_off == 'd1) out_q <= req_i.wdata[`CROC_GPIO_COUNT-1:0];
      if (wr && word_off == 'd3) mask_q <= req_i.wdata[`CROC_GPIO_COUNT-1:0];
      // New edge wins over a simultaneous clear
      pend_q <= (pend_q & ~clear) | rise;
    end
  end

  always_comb begin
    case (word_off)
      'd0:     read_data = data_t'(out_en_q);
      'd1:     read_data = data_t'(out_q);
      'd2:     read_data = data_t'(in_sync_q);
      'd3:     read_data = data_t'(mask_q);
      'd4:     read_data = data_t'(pend_q);
      default: read_data = '0;
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      rvalid_q <= 1'b0;
    end else begin
      rvalid_q <= accept;
    end
  end

  always_ff @(posedge clk_i) begin
    if (accept) begin
      rdata_q <= req_i.we ? '0 : read_data;
    end
  end

  assign rsp_o.gnt    = req_i.req;
  assign rsp_o.rvalid = rvalid_q;
  assign rsp_o.rdata  = rdata_q;
  assign rsp_o.err    = 1'b0;

  assign gpio_o         = out_q;
  assign gpio_out_en_o  = out_en_q;
  assign gpio_in_sync_o = in_sync_q;
  assign irq_o          = |(pend_q & mask_q);

endmodule

//--- design/soc_ctrl_regs.sv
`include "croc_lite_macros.svh"

module soc_ctrl_regs (
  input  logic                    clk_i,
  input  logic                    rst_i,
  input  croc_lite_pkg::bus_req_t req_i,
  output croc_lite_pkg::bus_rsp_t rsp_o,
  input  logic                    fetch_en_i,
  output croc_lite_pkg::addr_t    boot_addr_o,
  output logic                    fetch_enable_o
);
  import croc_lite_pkg::*;

  localparam int unsigned OffW = $clog2(`CROC_PERIPH_SIZE);

  logic [OffW-3:0] word_off;
  logic            accept;
  addr_t           boot_addr_q;
  logic            fetch_en_q;
  logic            rvalid_q;
  data_t           rdata_q;
  data_t           read_data;

  assign accept   = req_i.req;
  assign word_off = req_i.addr[OffW-1:2];

  // Boot address at 0x0, fetch enable at 0x4
  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      boot_addr_q <= `CROC_SRAM_BASE;
      fetch_en_q  <= 1'b0;
    end else if (accept && req_i.we) begin
      if (word_off == 'd0) begin
        for (int b = 0; b < `CROC_DATA_W / 8; b++) begin
          if (req_i.be[b]) begin
            boot_addr_q[b*8 +: 8] <= req_i.wdata[b*8 +: 8];
          end
        end
      end
      if (word_off == 'd1 && req_i.be[0]) begin
        fetch_en_q <= req_i.wdata[0];
      end
    end
  end

  // Unnamed offsets read as zero
  always_comb begin
    case (word_off)
      'd0:     read_data = boot_addr_q;
      'd1:     read_data = data_t'(fetch_en_q);
      default: read_data = '0;
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      rvalid_q <= 1'b0;
    end else begin
      rvalid_q <= accept;
    end
  end

  always_ff @(posedge clk_i) begin
    if (accept) begin
      rdata_q <= req_i.we ? '0 : read_data;
    end
  end

  assign rsp_o.gnt    = req_i.req;
  assign rsp_o.rvalid = rvalid_q;
  assign rsp_o.rdata  = rdata_q;
  assign rsp_o.err    = 1'b0;

  assign boot_addr_o    = boot_addr_q;
  assign fetch_enable_o = fetch_en_q & fetch_en_i;

endmodule

//--- design/sram_bank.sv
`include "croc_lite_macros.svh"

module sram_bank (
  input  logic                    clk_i,
  input  logic                    rst_i,
  input  croc_lite_pkg::bus_req_t req_i,
  output croc_lite_pkg::bus_rsp_t rsp_o
);
  import croc_lite_pkg::*;

  localparam int unsigned IdxW = $clog2(`CROC_SRAM_WORDS);

  data_t           mem [`CROC_SRAM_WORDS];
  logic [IdxW-1:0] word_idx;
  logic            accept;
  logic            rvalid_q;
  data_t           rdata_q;

  // Always ready, so every request is accepted on arrival
  assign accept   = req_i.req;
  assign word_idx = req_i.addr[IdxW+1:2];

  // Byte-masked write port
  always_ff @(posedge clk_i) begin
    if (accept && req_i.we) begin
      for (int b = 0; b < `CROC_DATA_W / 8; b++) begin
        if (req_i.be[b]) begin
          mem[word_idx][b*8 +: 8] <= req_i.wdata[b*8 +: 8];
        end
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (accept) begin
      rdata_q <= req_i.we ? '0 : mem[word_idx];
    end
  end

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      rvalid_q <= 1'b0;
    end else begin
      rvalid_q <= accept;
    end
  end

  assign rsp_o.gnt    = req_i.req;
  assign rsp_o.rvalid = rvalid_q;
  assign rsp_o.rdata  = rdata_q;
  assign rsp_o.err    = 1'b0;

endmodule

//--- design/timer_unit.sv
`include "croc_lite_macros.svh"

module timer_unit (
  input  logic                    clk_i,
  input  logic                    rst_i,
  input  croc_lite_pkg::bus_req_t req_i,
  output croc_lite_pkg::bus_rsp_t rsp_o,
  output logic                    irq_o
);
  import croc_lite_pkg::*;

  localparam int unsigned OffW = $clog2(`CROC_PERIPH_SIZE);

  logic [OffW-3:0] word_off;
  logic            accept;
  logic            wr;
  data_t           count_q;
  data_t           cmp_q;
  logic            en_q;
  logic            match;
  logic            irq_q;
  logic            rvalid_q;
  data_t           rdata_q;
  data_t           read_data;

  assign accept   = req_i.req;
  assign wr       = accept && req_i.we;
  assign word_off = req_i.addr[OffW-1:2];
  assign match    = en_q && (count_q == cmp_q);

  // Bus write to the counter beats wrap and increment
  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      count_q <= '0;
      cmp_q   <= '0;
      en_q    <= 1'b0;
      irq_q   <= 1'b0;
    end else begin
      irq_q <= match;
      if (wr && word_off == 'd0) begin
        count_q <= req_i.wdata;
      end else if (match) begin
        count_q <= '0;
      end else if (en_q) begin
        count_q <= count_q + 1'b1;
      end
      if (wr && word_off == 'd1) cmp_q <= req_i.wdata;
      if (wr && word_off == 'd2) en_q <= req_i.wdata[0];
    end
  end

  always_comb begin
    case (word_off)
      'd0:     read_data = count_q;
      'd1:     read_data = cmp_q;
      'd2:     read_data = data_t'(en_q);
      default: read_data = '0;
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      rvalid_q <= 1'b0;
    end else begin
      rvalid_q <= accept;
    end
  end

  always_ff @(posedge clk_i) begin
    if (accept) begin
      rdata_q <= req_i.we ? '0 : read_data;
    end
  end

  assign rsp_o.gnt    = req_i.req;
  assign rsp_o.rvalid = rvalid_q;
  assign rsp_o.rdata  = rdata_q;
  assign rsp_o.err    = 1'b0;

  // One-cycle pulse after each compare match
  assign irq_o = irq_q;

endmodule

//--- tests/croc_lite_asserts.sv
module croc_lite_asserts (
  input logic                    clk_i,
  input logic                    rst_i,
  input croc_lite_pkg::bus_req_t req_i,
  input croc_lite_pkg::bus_rsp_t rsp_i,
  input croc_lite_pkg::irq_vec_t irqs_i
);
  timeunit 1ns;
  timeprecision 1ps;

  logic accept;

  assign accept = req_i.req && rsp_i.gnt;

  // Fixed one-cycle response latency
  rvalid_after_accept: assert property (
    @(posedge clk_i) disable iff (rst_i) accept |=> rsp_i.rvalid
  ) else $error("rvalid missing one cycle after an accepted request");

  rvalid_needs_accept: assert property (
    @(posedge clk_i) disable iff (rst_i) rsp_i.rvalid |-> $past(accept)
  ) else $error("rvalid high without an accepted request one cycle before");

  // First reset edge clears the flops, later reset cycles show zero
  irqs_low_in_reset: assert property (
    @(posedge clk_i) rst_i |=> (!rst_i || irqs_i == '0)
  ) else $error("interrupt vector not zero during reset");

endmodule

bind croc_lite_domain croc_lite_asserts asserts0 (
  .clk_i  ( clk_i     ),
  .rst_i  ( rst_i     ),
  .req_i  ( bus_req_i ),
  .rsp_i  ( bus_rsp_o ),
  .irqs_i ( irqs_o    )
);

//--- tests/croc_lite_tb.sv
`include "croc_lite_macros.svh"

module croc_lite_tb;
  timeunit 1ns;
  timeprecision 1ps;

  import croc_lite_pkg::*;

  localparam int BusTimeout  = 20;
  localparam int SyncTimeout = 10;
  localparam int IrqTimeout  = 200;

  logic                          clk;
  logic                          rst;
  logic                          fetch_en;
  bus_req_t                      bus_req;
  bus_rsp_t                      bus_rsp;
  gpio_t                         gpio_in;
  gpio_t                         gpio_out;
  gpio_t                         gpio_oe;
  gpio_t                         gpio_sync;
  logic [`CROC_NUM_EXT_IRQS-1:0] irqs_in;
  irq_vec_t                      irqs_out;
  addr_t                         boot_addr;
  logic                          fetch_enable;

  // Reference model state
  data_t sram_model [`CROC_SRAM_WORDS];
  addr_t boot_model;
  gpio_t oe_model;
  gpio_t out_model;

  int checks_passed;
  int checks_failed;
  int test_errors;

  croc_lite_domain dut0 (
    .clk_i          ( clk          ),
    .rst_i          ( rst          ),
    .fetch_en_i     ( fetch_en     ),
    .bus_req_i      ( bus_req      ),
    .bus_rsp_o      ( bus_rsp      ),
    .gpio_i         ( gpio_in      ),
    .gpio_o         ( gpio_out     ),
    .gpio_out_en_o  ( gpio_oe      ),
    .gpio_in_sync_o ( gpio_sync    ),
    .irqs_i         ( irqs_in      ),
    .irqs_o         ( irqs_out     ),
    .boot_addr_o    ( boot_addr    ),
    .fetch_enable_o ( fetch_enable )
  );

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  // ----------------------------------------
  // Helpers
  // ----------------------------------------
  task automatic step();
    @(posedge clk);
    #1;
  endtask

  task automatic check_equal(input string name, input logic [31:0] expected,
                             input logic [31:0] actual);
    if (actual !== expected) begin
      $display("ERROR %s expected %h got %h", name, expected, actual);
      checks_failed++;
      test_errors++;
    end else begin
      checks_passed++;
    end
  endtask

  task automatic check_true(input logic cond, input string what);
    if (cond !== 1'b1) begin
      $display("Failure: %s", what);
      checks_failed++;
      test_errors++;
    end else begin
      checks_passed++;
    end
  endtask

  task automatic finish_test(input string name);
    $display("%-14s %s, %0d errors", name, (test_errors == 0) ? "pass" : "fail",
             test_errors);
    test_errors = 0;
  endtask

  function automatic data_t merge_bytes(input data_t old_word, input data_t new_word,
                                        input strb_t be);
    data_t result;
    result = old_word;
    for (int b = 0; b < 4; b++) begin
      if (be[b]) begin
        result[b*8 +: 8] = new_word[b*8 +: 8];
      end
    end
    return result;
  endfunction

  // Initial SRAM contents, unique per byte address
  function automatic data_t fill_word(input addr_t addr);
    return {addr[15:0], addr[31:16]} ^ 32'h5A5A_C3C3;
  endfunction

  function automatic logic is_mapped(input addr_t addr);
    addr_t page;
    page = addr & ~addr_t'(`CROC_PERIPH_SIZE - 1);
    return (addr >= `CROC_SRAM_BASE && addr < `CROC_SRAM_BASE + `CROC_SRAM_WORDS * 4) ||
           page == `CROC_SOC_CTRL_BASE || page == `CROC_GPIO_BASE ||
           page == `CROC_TIMER_BASE;
  endfunction

  // ----------------------------------------
  // Bus access
  // ----------------------------------------
  task automatic bus_access(input logic we, input addr_t addr, input data_t wdata,
                            input strb_t be, output data_t rdata, output logic err);
    int   cycles;
    logic granted;
    bus_req.req   = 1'b1;
    bus_req.we    = we;
    bus_req.be    = be;
    bus_req.addr  = addr;
    bus_req.wdata = wdata;
    cycles  = 0;
    granted = 1'b0;
    while (!granted && cycles < BusTimeout) begin
      @(negedge clk);
      granted = bus_rsp.gnt;
      @(posedge clk);
      cycles++;
    end
    #1;
    bus_req.req = 1'b0;
    rdata = '0;
    err   = 1'b0;
    if (!granted) begin
      check_true(1'b0, $sformatf("no grant for address %h", addr));
    end else begin
      cycles = 0;
      while (!bus_rsp.rvalid && cycles < BusTimeout) begin
        step();
        cycles++;
      end
      check_true(bus_rsp.rvalid, $sformatf("no response for address %h", addr));
      rdata = bus_rsp.rdata;
      err   = bus_rsp.err;
    end
  endtask

  task automatic write_reg(input addr_t addr, input data_t wdata);
    data_t rdata;
    logic  err;
    bus_access(1'b1, addr, wdata, 4'hF, rdata, err);
    check_equal("bus_rsp_o.err", 32'h0, err);
  endtask

  task automatic read_reg(input addr_t addr, output data_t rdata);
    logic err;
    bus_access(1'b0, addr, '0, 4'hF, rdata, err);
    check_equal("bus_rsp_o.err", 32'h0, err);
  endtask

  task automatic wait_gpio_sync(input gpio_t value);
    int cycles;
    cycles = 0;
    while (gpio_sync !== value && cycles < SyncTimeout) begin
      step();
      cycles++;
    end
    check_equal("gpio_in_sync_o", value, gpio_sync);
  endtask

  // ----------------------------------------
  // Tests
  // ----------------------------------------
  task automatic test_soc_ctrl();
    data_t wdata;
    data_t rdata;
    strb_t be;
    logic  err;
    // Pin high exposes the register reset value
    fetch_en = 1'b1;
    step();
    check_equal("boot_addr_o", `CROC_SRAM_BASE, boot_addr);
    check_equal("fetch_enable_o", 32'h0, fetch_enable);
    boot_model = `CROC_SRAM_BASE;
    for (int n = 0; n < 10; n++) begin
      wdata      = $urandom;
      be         = strb_t'($urandom_range(15));
      boot_model = merge_bytes(boot_model, wdata, be);
      bus_access(1'b1, `CROC_SOC_CTRL_BASE, wdata, be, rdata, err);
      check_equal("bus_rsp_o.err", 32'h0, err);
      check_equal("boot_addr_o", boot_model, boot_addr);
      read_reg(`CROC_SOC_CTRL_BASE, rdata);
      check_equal("bus_rsp_o.rdata boot address", boot_model, rdata);
    end
    // Register bit against pin, all four pairs
    for (int c = 0; c < 4; c++) begin
      write_reg(`CROC_SOC_CTRL_BASE + 4, data_t'(c[0]));
      fetch_en = c[1];
      step();
      check_equal("fetch_enable_o", c[0] & c[1], fetch_enable);
    end
    fetch_en = 1'b0;
    finish_test("soc_ctrl");
  endtask

  task automatic test_sram();
    addr_t addr;
    data_t wdata;
    data_t rdata;
    strb_t be;
    logic  err;
    int    idx;
    for (int i = 0; i < `CROC_SRAM_WORDS; i++) begin
      addr          = `CROC_SRAM_BASE + i * 4;
      sram_model[i] = fill_word(addr);
      bus_access(1'b1, addr, sram_model[i], 4'hF, rdata, err);
    end
    for (int n = 0; n < 200; n++) begin
      idx  = $urandom_range(`CROC_SRAM_WORDS - 1);
      addr = `CROC_SRAM_BASE + idx * 4;
      if ($urandom_range(1) == 1) begin
        wdata           = $urandom;
        be              = strb_t'($urandom_range(15));
        sram_model[idx] = merge_bytes(sram_model[idx], wdata, be);
        bus_access(1'b1, addr, wdata, be, rdata, err);
        check_equal("bus_rsp_o.rdata sram write", 32'h0, rdata);
      end else begin
        bus_access(1'b0, addr, '0, 4'hF, rdata, err);
        check_equal("bus_rsp_o.rdata sram read", sram_model[idx], rdata);
      end
      check_equal("bus_rsp_o.err", 32'h0, err);
    end
    finish_test("sram");
  endtask

  task automatic test_unmapped();
    addr_t addr;
    data_t rdata;
    logic  err;
    for (int n = 0; n < 20; n++) begin
      if (n == 0) begin
        addr = `CROC_SRAM_BASE + `CROC_SRAM_WORDS * 4;
      end else if (n == 1) begin
        addr = `CROC_TIMER_BASE + `CROC_PERIPH_SIZE;
      end else begin
        addr = $urandom;
      end
      // Top bit flip moves any mapped address out of the map
      if (is_mapped(addr)) begin
        addr = addr ^ 32'h8000_0000;
      end
      bus_access(1'($urandom_range(1)), addr, $urandom, 4'hF, rdata, err);
      check_equal("bus_rsp_o.err", 32'h1, err);
      check_equal("bus_rsp_o.rdata", `CROC_ERR_RDATA, rdata);
    end
    finish_test("unmapped");
  endtask

  task automatic test_gpio_out();
    data_t wdata;
    data_t rdata;
    for (int n = 0; n < 10; n++) begin
      wdata    = $urandom;
      oe_model = gpio_t'(wdata);
      write_reg(`CROC_GPIO_BASE, wdata);
      check_equal("gpio_out_en_o", oe_model, gpio_oe);
      wdata     = $urandom;
      out_model = gpio_t'(wdata);
      write_reg(`CROC_GPIO_BASE + 4, wdata);
      check_equal("gpio_o", out_model, gpio_out);
      read_reg(`CROC_GPIO_BASE, rdata);
      check_equal("bus_rsp_o.rdata gpio output enable", oe_model, rdata);
      read_reg(`CROC_GPIO_BASE + 4, rdata);
      check_equal("bus_rsp_o.rdata gpio output", out_model, rdata);
    end
    finish_test("gpio_out");
  endtask

  task automatic test_gpio_in();
    data_t rdata;
    int    bit_sel;
    int    cycles;
    for (int n = 0; n < 5; n++) begin
      gpio_in = gpio_t'($urandom);
      wait_gpio_sync(gpio_in);
      read_reg(`CROC_GPIO_BASE + 8, rdata);
      check_equal("bus_rsp_o.rdata gpio input", gpio_in, rdata);
    end
    // Quiet inputs, then drop every pending edge
    gpio_in = '0;
    wait_gpio_sync('0);
    step();
    write_reg(`CROC_GPIO_BASE + 16, 32'h0000_FFFF);
    read_reg(`CROC_GPIO_BASE + 16, rdata);
    check_equal("bus_rsp_o.rdata gpio pending", 32'h0, rdata);
    bit_sel = $urandom_range(`CROC_GPIO_COUNT - 1);
    write_reg(`CROC_GPIO_BASE + 12, 32'h1 << bit_sel);
    check_equal("irqs_o[1]", 32'h0, irqs_out[1]);
    gpio_in[bit_sel] = 1'b1;
    cycles = 0;
    while (!irqs_out[1] && cycles < SyncTimeout) begin
      step();
      cycles++;
    end
    check_true(irqs_out[1], $sformatf("GPIO interrupt did not rise for pin %0d", bit_sel));
    write_reg(`CROC_GPIO_BASE + 16, 32'h1 << bit_sel);
    check_equal("irqs_o[1]", 32'h0, irqs_out[1]);
    for (int n = 0; n < 8; n++) begin
      irqs_in = $urandom;
      step();
      check_equal("irqs_o[5:2]", irqs_in, irqs_out[`CROC_NUM_EXT_IRQS+1:2]);
    end
    irqs_in = '0;
    finish_test("gpio_in_irq");
  endtask

  task automatic test_timer();
    data_t first;
    data_t second;
    logic  seen;
    int    cycles;
    write_reg(`CROC_TIMER_BASE + 4, 32'd50);
    write_reg(`CROC_TIMER_BASE + 8, 32'h1);
    seen   = 1'b0;
    cycles = 0;
    while (!seen && cycles < IrqTimeout) begin
      step();
      seen = irqs_out[0];
      cycles++;
    end
    check_true(seen, "timer interrupt did not pulse");
    step();
    check_equal("irqs_o[0]", 32'h0, irqs_out[0]);
    // Far compare value, no wrap between the two reads
    write_reg(`CROC_TIMER_BASE + 4, 32'hFFFF_FFFF);
    read_reg(`CROC_TIMER_BASE, first);
    read_reg(`CROC_TIMER_BASE, second);
    check_true(second > first,
               $sformatf("timer count did not increase, %h then %h", first, second));
    write_reg(`CROC_TIMER_BASE + 8, 32'h0);
    read_reg(`CROC_TIMER_BASE, first);
    read_reg(`CROC_TIMER_BASE, second);
    check_equal("bus_rsp_o.rdata timer count", first, second);
    finish_test("timer");
  endtask

  // ----------------------------------------
  // Main sequence
  // ----------------------------------------
  initial begin
    void'($urandom(32'h75ce));
    checks_passed = 0;
    checks_failed = 0;
    test_errors   = 0;
    rst           = 1'b1;
    fetch_en      = 1'b0;
    bus_req       = '0;
    gpio_in       = '0;
    irqs_in       = '0;
    repeat (8) @(posedge clk);
    #1;
    rst = 1'b0;

    test_soc_ctrl();
    test_sram();
    test_unmapped();
    test_gpio_out();
    test_gpio_in();
    test_timer();

    $display("checks passed: %0d, checks failed: %0d", checks_passed, checks_failed);
    if (checks_failed == 0) begin
      $display("ALL TESTS PASSED");
    end else begin
      $display("SOME TESTS FAILED");
    end
    $finish;
  end

endmodule
